// ==== Bender.yml ====
package:
  name: wb_master

sources:
  - hdl/wb_master_pkg.sv
  - hdl/wb_req_if.sv
  - hdl/wb_port_arbiter.sv
  - hdl/wb_cycle_fsm.sv
  - hdl/wb_beat_counter.sv
  - hdl/wb_bus_driver.sv
  - hdl/wb_master_top.sv
  - target: test
    files:
      - tb/wb_master_props.sv
      - tb/tb_wb_master.sv

// ==== hdl/wb_beat_counter.sv ====
// ==============================
// wishbone beat counter
// counts the beats still to come in a transfer
// ==============================

`timescale 1ns/10ps
`default_nettype none

module wb_beat_counter
(
    input  wire logic i_clk,
    input  wire logic quick_n_reset,
    input  wire logic i_start,
    input  wire logic i_qword,
    input  wire logic i_beat_ack,
    output logic      o_last
);
    import wb_master_pkg::*;

    // beats that follow the current one
    beat_cnt_t cnt_r;

    always_ff @(posedge i_clk)
    begin
        if (!quick_n_reset)
            cnt_r <= '0;
        else if (i_start)
            // a line fill has three beats after the first, a single word none
            cnt_r <= i_qword ? beat_cnt_t'(BURST_BEATS - 1) : '0;
        else if (i_beat_ack && (cnt_r != '0))
            cnt_r <= cnt_r - 2'd1;
    end

    // the ack taken with this high leaves only the final beat
    assign o_last = (cnt_r == 2'd1);

endmodule

`default_nettype wire

// ==== hdl/wb_bus_driver.sv ====
// ==============================
// wishbone bus driver
// registers the bus outputs, derives the low address bits
// and steps the word index through a wrapping line burst
// ==============================

`timescale 1ns/10ps
`default_nettype none

module wb_bus_driver
(
    input  wire logic                              i_clk,
    input  wire logic                              quick_n_reset,
    input  wire logic                              i_start,
    input  wire logic                              i_beat_ack,
    input  wire logic                              i_done,
    wb_req_if.drv                                  req,
    output logic      [wb_master_pkg::ADDR_W-1:0]  o_wb_adr,
    output logic      [wb_master_pkg::SEL_W-1:0]   o_wb_sel,
    output logic                                   o_wb_we,
    output logic      [wb_master_pkg::DATA_W-1:0]  o_wb_dat,
    output logic                                   o_wb_cyc,
    output logic                                   o_wb_stb
);
    import wb_master_pkg::*;

    wb_addr_u  adr_r;
    wb_addr_u  start_adr;
    logic [1:0] be_offset;

    // ==============================
    // start address
    // ==============================

    // byte offset implied by the enables, only whole bytes and halves are exact
    always_comb
    begin
        case (req.be)
            4'b0001: be_offset = 2'd0;
            4'b0010: be_offset = 2'd1;
            4'b0100: be_offset = 2'd2;
            4'b1000: be_offset = 2'd3;
            4'b1100: be_offset = 2'd2;
            default: be_offset = 2'd0;
        endcase
    end

    // reads are word aligned, a burst starts at the requested word
    always_comb
    begin
        start_adr               = req.addr;
        start_adr.line.byte_off = req.write ? be_offset : 2'd0;
    end

    // ==============================
    // bus registers
    // ==============================

    // cycle control, stb stays up across all beats of a burst
    always_ff @(posedge i_clk)
    begin
        if (!quick_n_reset)
        begin
            o_wb_cyc <= 1'b0;
            o_wb_stb <= 1'b0;
            o_wb_we  <= 1'b0;
        end
        else if (i_start)
        begin
            o_wb_cyc <= 1'b1;
            o_wb_stb <= 1'b1;
            o_wb_we  <= req.write;
        end
        else if (i_done)
        begin
            o_wb_cyc <= 1'b0;
            o_wb_stb <= 1'b0;
            o_wb_we  <= 1'b0;
        end
    end

    // address, select and data only move on start or an acked beat
    always_ff @(posedge i_clk)
    begin
        if (i_start)
        begin
            adr_r    <= start_adr;
            o_wb_sel <= req.write ? req.be : SEL_ALL;
            o_wb_dat <= req.wdata;
        end
        else if (i_beat_ack && !i_done)
            // two bit index, so the burst wraps inside the 16-byte line
            adr_r.line.word <= adr_r.line.word + 2'd1;
    end

    assign o_wb_adr = adr_r.raw;

endmodule

`default_nettype wire

// ==== hdl/wb_cycle_fsm.sv ====
// ==============================
// wishbone cycle FSM
// starts a bus cycle for the granted request, qualifies
// each ack as a beat and ends the cycle on the last one
// ==============================

`timescale 1ns/10ps
`default_nettype none

module wb_cycle_fsm
(
    input  wire logic i_clk,
    input  wire logic quick_n_reset,
    // slave acknowledge, only looked at here
    input  wire logic i_wb_ack,
    // from the beat counter, one beat left after this one
    input  wire logic i_last,
    wb_req_if.ctrl    req,
    output logic      o_start,
    output logic      o_beat_ack,
    output logic      o_done
);
    import wb_master_pkg::*;

    wb_state_t state_r;
    wb_state_t state_nxt;

    // ==============================
    // next state and cycle events
    // ==============================

    always_comb
    begin
        state_nxt  = state_r;
        o_start    = 1'b0;
        o_beat_ack = 1'b0;
        o_done     = 1'b0;
        case (state_r)
            IDLE:
            begin
                // a held request starts the cycle at once
                if (req.valid)
                begin
                    o_start   = 1'b1;
                    state_nxt = req.qword ? BURST : WAIT_ACK;
                end
            end
            BURST:
            begin
                // every ack in a burst is a beat, the slave may stall as long as it likes
                o_beat_ack = i_wb_ack;
                if (i_wb_ack && i_last)
                    state_nxt = WAIT_ACK;
            end
            WAIT_ACK:
            begin
                // the final beat of any transfer is taken here
                o_beat_ack = i_wb_ack;
                if (i_wb_ack)
                begin
                    o_done    = 1'b1;
                    state_nxt = IDLE;
                end
            end
            default:
            begin
                state_nxt = IDLE;
            end
        endcase
    end

    // ==============================
    // state register
    // ==============================

    always_ff @(posedge i_clk)
    begin
        if (!quick_n_reset)
            state_r <= IDLE;
        else
            state_r <= state_nxt;
    end

endmodule

`default_nettype wire

// ==== hdl/wb_master_pkg.sv ====
// ==============================
// wishbone master shared definitions
// bus widths, burst length, state encoding and the
// address word with its cache line view
// ==============================

`default_nettype none

package wb_master_pkg;

    // ==============================
    // bus widths
    // ==============================

    // byte addressed 32-bit bus with one select bit per byte
    parameter int ADDR_W = 32;
    parameter int DATA_W = 32;
    parameter int SEL_W  = 4;

    // a cache line is four words, so a line fill is four beats
    parameter int BURST_BEATS = 4;

    // reads always fetch the whole word
    parameter logic [SEL_W-1:0] SEL_ALL = {SEL_W{1'b1}};

    // ==============================
    // types
    // ==============================

    // remaining beats after the current one, 0 to 3
    typedef logic [1:0] beat_cnt_t;

    // bus cycle states, a burst covers all beats but the final one
    typedef enum logic [1:0]
    {
        IDLE     = 2'd0,
        BURST    = 2'd1,
        WAIT_ACK = 2'd2
    } wb_state_t;

    // one address word, seen either as the raw bus address or split
    // into the line tag, the word inside the 16-byte line and the byte
    typedef union packed
    {
        logic [ADDR_W-1:0] raw;
        struct packed
        {
            logic [ADDR_W-5:0] tag;
            logic [1:0]        word;
            logic [1:0]        byte_off;
        } line;
    } wb_addr_u;

endpackage

`default_nettype wire

// ==== hdl/wb_master_top.sv ====
// ==============================
// wishbone master top level
// serves a fetch port and a data port over one
// wishbone bus, with the data port first
// ==============================

`timescale 1ns/10ps
`default_nettype none

module wb_master_top
(
    input  wire logic                             i_clk,
    input  wire logic                             quick_n_reset,
    // fetch port
    input  wire logic                             i_icache_req,
    input  wire logic                             i_icache_qword,
    input  wire logic [wb_master_pkg::ADDR_W-1:0] i_icache_address,
    output logic      [wb_master_pkg::DATA_W-1:0] o_icache_read_data,
    output logic                                  o_icache_ready,
    // data port
    input  wire logic                             i_dcache_req,
    input  wire logic                             i_dcache_write,
    input  wire logic                             i_dcache_qword,
    input  wire logic [wb_master_pkg::ADDR_W-1:0] i_dcache_address,
    input  wire logic [wb_master_pkg::DATA_W-1:0] i_dcache_write_data,
    input  wire logic [wb_master_pkg::SEL_W-1:0]  i_dcache_byte_enable,
    output logic      [wb_master_pkg::DATA_W-1:0] o_dcache_read_data,
    output logic                                  o_dcache_ready,
    // wishbone bus
    output logic      [wb_master_pkg::ADDR_W-1:0] o_wb_adr,
    output logic      [wb_master_pkg::SEL_W-1:0]  o_wb_sel,
    output logic                                  o_wb_we,
    output logic      [wb_master_pkg::DATA_W-1:0] o_wb_dat,
    output logic                                  o_wb_cyc,
    output logic                                  o_wb_stb,
    input  wire logic [wb_master_pkg::DATA_W-1:0] i_wb_dat,
    input  wire logic                             i_wb_ack
);

    logic start;
    logic beat_ack;
    logic done;
    logic last;

    // granted request shared by arbiter, FSM and driver
    wb_req_if req_bus ();

    wb_port_arbiter wb_port_arbiter_inst
    (
        .i_clk                (i_clk),
        .quick_n_reset        (quick_n_reset),
        .i_icache_req         (i_icache_req),
        .i_icache_qword       (i_icache_qword),
        .i_icache_address     (i_icache_address),
        .i_dcache_req         (i_dcache_req),
        .i_dcache_write       (i_dcache_write),
        .i_dcache_qword       (i_dcache_qword),
        .i_dcache_address     (i_dcache_address),
        .i_dcache_write_data  (i_dcache_write_data),
        .i_dcache_byte_enable (i_dcache_byte_enable),
        .i_start              (start),
        .i_beat_ack           (beat_ack),
        .i_done               (done),
        .o_icache_ready       (o_icache_ready),
        .o_dcache_ready       (o_dcache_ready),
        .req                  (req_bus.arb)
    );

    wb_cycle_fsm wb_cycle_fsm_inst
    (
        .i_clk         (i_clk),
        .quick_n_reset (quick_n_reset),
        .i_wb_ack      (i_wb_ack),
        .i_last        (last),
        .req           (req_bus.ctrl),
        .o_start       (start),
        .o_beat_ack    (beat_ack),
        .o_done        (done)
    );

    wb_beat_counter wb_beat_counter_inst
    (
        .i_clk         (i_clk),
        .quick_n_reset (quick_n_reset),
        .i_start       (start),
        .i_qword       (req_bus.qword),
        .i_beat_ack    (beat_ack),
        .o_last        (last)
    );

    wb_bus_driver wb_bus_driver_inst
    (
        .i_clk         (i_clk),
        .quick_n_reset (quick_n_reset),
        .i_start       (start),
        .i_beat_ack    (beat_ack),
        .i_done        (done),
        .req           (req_bus.drv),
        .o_wb_adr      (o_wb_adr),
        .o_wb_sel      (o_wb_sel),
        .o_wb_we       (o_wb_we),
        .o_wb_dat      (o_wb_dat),
        .o_wb_cyc      (o_wb_cyc),
        .o_wb_stb      (o_wb_stb)
    );

    // read data goes to both ports, the ready pulse tells which one takes it
    assign o_icache_read_data = i_wb_dat;
    assign o_dcache_read_data = i_wb_dat;

endmodule

`default_nettype wire

// ==== hdl/wb_port_arbiter.sv ====
// ==============================
// wishbone port arbiter
// latches fetch and data requests, grants the data port
// first and routes the ready pulses back to the owner
// ==============================

`timescale 1ns/10ps
`default_nettype none

module wb_port_arbiter
(
    input  wire logic                             i_clk,
    input  wire logic                             quick_n_reset,
    // fetch port
    input  wire logic                             i_icache_req,
    input  wire logic                             i_icache_qword,
    input  wire logic [wb_master_pkg::ADDR_W-1:0] i_icache_address,
    // data port
    input  wire logic                             i_dcache_req,
    input  wire logic                             i_dcache_write,
    input  wire logic                             i_dcache_qword,
    input  wire logic [wb_master_pkg::ADDR_W-1:0] i_dcache_address,
    input  wire logic [wb_master_pkg::DATA_W-1:0] i_dcache_write_data,
    input  wire logic [wb_master_pkg::SEL_W-1:0]  i_dcache_byte_enable,
    // cycle events from the FSM
    input  wire logic                             i_start,
    input  wire logic                             i_beat_ack,
    input  wire logic                             i_done,
    output logic                                  o_icache_ready,
    output logic                                  o_dcache_ready,
    wb_req_if.arb                                 req
);
    import wb_master_pkg::*;

    logic icache_pend;
    logic dcache_pend;
    logic grant;
    logic in_flight_r;
    logic done_q;

    // the port that was just served is masked for one cycle while its
    // requester takes req down, so a stale req is never granted twice
    assign icache_pend = i_icache_req && !(done_q && !req.is_data);
    assign dcache_pend = i_dcache_req && !(done_q && req.is_data);

    // a new grant is only taken when nothing is held
    assign grant = !req.valid && (icache_pend || dcache_pend);

    // ==============================
    // grant and cycle tracking
    // ==============================

    always_ff @(posedge i_clk)
    begin
        if (!quick_n_reset)
        begin
            req.valid   <= 1'b0;
            req.is_data <= 1'b0;
            req.write   <= 1'b0;
            req.qword   <= 1'b0;
            in_flight_r <= 1'b0;
            done_q      <= 1'b0;
        end
        else
        begin
            done_q <= i_done;
            if (i_done)
                req.valid <= 1'b0;
            else if (grant)
            begin
                req.valid   <= 1'b1;
                // data wins whenever both ports are pending
                req.is_data <= dcache_pend;
                req.write   <= dcache_pend && i_dcache_write;
                // writes are always single word
                req.qword   <= dcache_pend ? (i_dcache_qword && !i_dcache_write)
                                           : i_icache_qword;
            end
            // readies are only routed while the bus cycle runs
            if (i_start)
                in_flight_r <= 1'b1;
            else if (i_done)
                in_flight_r <= 1'b0;
        end
    end

    // request payload is captured once per grant
    always_ff @(posedge i_clk)
    begin
        if (grant)
        begin
            if (dcache_pend)
            begin
                req.addr.raw <= i_dcache_address;
                req.wdata    <= i_dcache_write_data;
                req.be       <= i_dcache_byte_enable;
            end
            else
            begin
                req.addr.raw <= i_icache_address;
                req.be       <= SEL_ALL;
            end
        end
    end

    // one pulse per acked beat, so a write gets one and a line fill four
    assign o_dcache_ready = in_flight_r && req.is_data && i_beat_ack;
    assign o_icache_ready = in_flight_r && !req.is_data && i_beat_ack;

endmodule

`default_nettype wire

// ==== hdl/wb_req_if.sv ====
// ==============================
// granted request bundle
// carries the request chosen by the arbiter to the
// cycle FSM and the bus driver
// ==============================

`timescale 1ns/10ps
`default_nettype none

interface wb_req_if;
    import wb_master_pkg::*;

    // valid holds, with every field stable, from grant until the FSM ends the cycle
    logic              valid;
    // set when the data port owns the request, clear for the fetch port
    logic              is_data;
    logic              write;
    // qword asks for a four beat line fill
    logic              qword;
    wb_addr_u          addr;
    logic [DATA_W-1:0] wdata;
    logic [SEL_W-1:0]  be;

    // the arbiter owns every field
    modport arb  (output valid, is_data, write, qword, addr, wdata, be);

    // the FSM only needs to know that a request waits and how long it is
    modport ctrl (input valid, qword);

    // the driver takes what goes out on the bus
    modport drv  (input write, addr, wdata, be);

endinterface

`default_nettype wire

// ==== tb/tb_wb_master.sv ====
// ==============================
// wishbone master testbench
// drives the fetch and data ports, models a slave with
// random wait states and reports each test
// ==============================

`timescale 1ns/10ps
`default_nettype none

module tb_wb_master;
    import wb_master_pkg::*;

    // the slave returns the bus address xor this pattern on reads
    localparam logic [31:0] RD_PAT = 32'h5a5a_0000;
    // six tests, each under 60 cycles at three wait states a beat, with plenty of margin
    localparam int MAX_CYCLES = 2000;

    logic              i_clk = 1'b0;
    logic              quick_n_reset;
    logic              i_icache_req;
    logic              i_icache_qword;
    logic [ADDR_W-1:0] i_icache_address;
    logic [DATA_W-1:0] o_icache_read_data;
    logic              o_icache_ready;
    logic              i_dcache_req;
    logic              i_dcache_write;
    logic              i_dcache_qword;
    logic [ADDR_W-1:0] i_dcache_address;
    logic [DATA_W-1:0] i_dcache_write_data;
    logic [SEL_W-1:0]  i_dcache_byte_enable;
    logic [DATA_W-1:0] o_dcache_read_data;
    logic              o_dcache_ready;
    logic [ADDR_W-1:0] o_wb_adr;
    logic [SEL_W-1:0]  o_wb_sel;
    logic              o_wb_we;
    logic [DATA_W-1:0] o_wb_dat;
    logic              o_wb_cyc;
    logic              o_wb_stb;
    logic [DATA_W-1:0] i_wb_dat = '0;
    logic              i_wb_ack = 1'b0;

    // slave model state
    integer            seed = 32'h2ea0;
    int                wait_left = 0;
    logic              armed = 1'b0;
    logic [ADDR_W-1:0] last_wr_adr = '0;
    logic [DATA_W-1:0] last_wr_dat = '0;
    logic [SEL_W-1:0]  last_wr_sel = '0;

    int  check_errors = 0;
    int  cycle_cnt = 0;
    int  tests_run = 0;
    int  tests_failed = 0;
    int  errors_at_start = 0;
    time data_ready_time = 0;
    time fetch_ready_time = 0;

    wb_master_top wb_master_top_inst (.*);

    initial
    begin
        forever #5 i_clk = ~i_clk;
    end

    // cycle limit so a stuck handshake cannot hang the run
    always @(posedge i_clk)
    begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES)
        begin
            $display("run stopped at the cycle limit before all tests finished");
            $display("Errors found");
            $finish;
        end
    end

    // ==============================
    // slave model
    // ==============================

    // an ack lasts one cycle, the next beat of a burst may follow right after it
    always @(negedge i_clk)
    begin
        i_wb_ack = 1'b0;
        if (!quick_n_reset)
            armed = 1'b0;
        else if (o_wb_cyc && o_wb_stb)
        begin
            if (!armed)
            begin
                wait_left = {$random(seed)} % 4;
                armed     = 1'b1;
            end
            if (wait_left == 0)
            begin
                i_wb_ack = 1'b1;
                armed    = 1'b0;
                i_wb_dat = o_wb_adr ^ RD_PAT;
                if (o_wb_we)
                begin
                    last_wr_adr = o_wb_adr;
                    last_wr_dat = o_wb_dat;
                    last_wr_sel = o_wb_sel;
                end
            end
            else
                wait_left = wait_left - 1;
        end
    end

    // ==============================
    // checks and reporting
    // ==============================

    function automatic int total_errors();
        return check_errors + wb_master_top_inst.props_inst.fail_count;
    endfunction

    task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp)
        else
        begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
            check_errors++;
        end
    endtask

    task automatic expect_true(input logic cond, input string what);
        assert (cond)
        else
        begin
            $display("at %0t: %s", $time, what);
            check_errors++;
        end
    endtask

    task automatic finish_test(input int num, input string name);
        int errs;
        errs = total_errors() - errors_at_start;
        tests_run++;
        if (errs != 0)
            tests_failed++;
        $display("test %0d %s: %s", num, name, (errs == 0) ? "pass" : "fail");
        errors_at_start = total_errors();
    endtask

    // ==============================
    // requesters
    // ==============================

    // holds req until every ready arrived, checking each beat as it is acked
    task automatic fetch_request(input logic [31:0] addr, input logic qword);
        int          beats;
        int          got;
        logic [31:0] exp_adr;
        beats   = qword ? BURST_BEATS : 1;
        got     = 0;
        exp_adr = {addr[31:2], 2'b00};
        @(negedge i_clk);
        i_icache_req     = 1'b1;
        i_icache_qword   = qword;
        i_icache_address = addr;
        while (got < beats)
        begin
            @(posedge i_clk);
            // once a burst has begun stb must stay up until its last beat
            if (got > 0)
                expect_eq("o_wb_stb", o_wb_stb, 1'b1);
            if (o_icache_ready)
            begin
                if (got == 0)
                    fetch_ready_time = $time;
                expect_eq("o_wb_adr", o_wb_adr, exp_adr);
                expect_eq("o_wb_sel", o_wb_sel, SEL_ALL);
                expect_eq("o_wb_we", o_wb_we, 1'b0);
                expect_eq("o_icache_read_data", o_icache_read_data, exp_adr ^ RD_PAT);
                // next word of the line, wrapping after the fourth
                exp_adr[3:2] = exp_adr[3:2] + 2'd1;
                got++;
            end
        end
        @(negedge i_clk);
        i_icache_req = 1'b0;
        @(posedge i_clk);
        expect_eq("o_wb_cyc", o_wb_cyc, 1'b0);
        expect_eq("o_wb_stb", o_wb_stb, 1'b0);
        expect_eq("o_icache_ready", o_icache_ready, 1'b0);
    endtask

    // single word data access, low_bits is the byte offset the enables imply
    task automatic data_request(input logic [31:0] addr, input logic write,
                                input logic [31:0] wdata, input logic [3:0] be,
                                input logic [1:0] low_bits);
        logic [31:0] exp_adr;
        exp_adr = {addr[31:2], write ? low_bits : 2'b00};
        @(negedge i_clk);
        i_dcache_req         = 1'b1;
        i_dcache_write       = write;
        i_dcache_qword       = 1'b0;
        i_dcache_address     = addr;
        i_dcache_write_data  = wdata;
        i_dcache_byte_enable = be;
        @(posedge i_clk);
        while (!o_dcache_ready)
            @(posedge i_clk);
        data_ready_time = $time;
        expect_eq("o_wb_adr", o_wb_adr, exp_adr);
        expect_eq("o_wb_we", o_wb_we, write);
        if (write)
        begin
            expect_eq("o_wb_sel", o_wb_sel, be);
            expect_eq("o_wb_dat", o_wb_dat, wdata);
            expect_eq("slave write data", last_wr_dat, wdata);
            expect_eq("slave write select", last_wr_sel, be);
            expect_eq("slave write address", last_wr_adr, exp_adr);
        end
        else
        begin
            expect_eq("o_wb_sel", o_wb_sel, SEL_ALL);
            expect_eq("o_dcache_read_data", o_dcache_read_data, exp_adr ^ RD_PAT);
        end
        @(negedge i_clk);
        i_dcache_req = 1'b0;
        @(posedge i_clk);
        expect_eq("o_wb_cyc", o_wb_cyc, 1'b0);
        expect_eq("o_wb_stb", o_wb_stb, 1'b0);
        expect_eq("o_dcache_ready", o_dcache_ready, 1'b0);
    endtask

    // ==============================
    // test sequence
    // ==============================

    initial
    begin
        quick_n_reset        = 1'b0;
        i_icache_req         = 1'b0;
        i_icache_qword       = 1'b0;
        i_icache_address     = '0;
        i_dcache_req         = 1'b0;
        i_dcache_write       = 1'b0;
        i_dcache_qword       = 1'b0;
        i_dcache_address     = '0;
        i_dcache_write_data  = '0;
        i_dcache_byte_enable = '0;
        repeat (5) @(negedge i_clk);
        quick_n_reset = 1'b1;

        @(negedge i_clk);
        expect_eq("o_wb_cyc", o_wb_cyc, 1'b0);
        expect_eq("o_wb_stb", o_wb_stb, 1'b0);
        expect_eq("o_wb_we", o_wb_we, 1'b0);
        expect_eq("o_icache_ready", o_icache_ready, 1'b0);
        expect_eq("o_dcache_ready", o_dcache_ready, 1'b0);
        finish_test(1, "reset state");

        fetch_request(32'h0000_0107, 1'b0);
        finish_test(2, "single fetch read");

        // starts at word 2, so the line is read as words 2, 3, 0, 1
        fetch_request(32'h0000_1008, 1'b1);
        finish_test(3, "fetch burst with wrap");

        data_request(32'h0000_2010, 1'b1, 32'h1122_3344, 4'b0010, 2'd1);
        data_request(32'h0000_2010, 1'b1, 32'h5566_7788, 4'b1100, 2'd2);
        data_request(32'h0000_2010, 1'b1, 32'h99aa_bbcc, 4'b0111, 2'd0);
        finish_test(4, "data writes with byte enables");

        // both ports raise req on the same falling edge
        fork
            data_request(32'h0000_3040, 1'b0, 32'h0, 4'hf, 2'd0);
            fetch_request(32'h0000_3100, 1'b0);
        join
        expect_true(data_ready_time < fetch_ready_time,
                    "fetch port was served before the data port");
        finish_test(5, "data port priority");

        for (int i = 0; i < 2; i++)
        begin
            fetch_request(32'h0000_4004 + (i << 4), 1'b1);
            data_request(32'h0000_5000 + (i << 2), 1'b1, 32'hc0de_0000 + i, 4'b1000, 2'd3);
        end
        finish_test(6, "back-pressure");

        repeat (4) @(negedge i_clk);
        $display("tests run %0d, tests failed %0d, failed checks %0d",
                 tests_run, tests_failed, total_errors());
        if (total_errors() == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/wb_master_props.sv ====
// ==============================
// wishbone master bus properties
// protocol checks on the bus and ready
// outputs of the top level
// ==============================

`timescale 1ns/10ps
`default_nettype none

module wb_master_props
(
    input wire logic                             i_clk,
    input wire logic                             quick_n_reset,
    input wire logic [wb_master_pkg::ADDR_W-1:0] i_adr,
    input wire logic [wb_master_pkg::SEL_W-1:0]  i_sel,
    input wire logic                             i_we,
    input wire logic [wb_master_pkg::DATA_W-1:0] i_dat,
    input wire logic                             i_cyc,
    input wire logic                             i_stb,
    input wire logic                             i_ack,
    input wire logic                             i_icache_ready,
    input wire logic                             i_dcache_ready
);
    import wb_master_pkg::*;

    // failed checks so far
    int fail_count = 0;

    // line view of the bus address
    wb_addr_u adr_view;
    assign adr_view.raw = i_adr;

    // a stalled beat keeps every bus field where it is
    hold_check: assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        (i_stb && !i_ack) |=> ($stable(i_adr) && $stable(i_sel) && $stable(i_we)
                               && $stable(i_dat)))
    else
    begin
        fail_count++;
        $error("bus fields moved while a beat was stalled");
    end

    stb_cyc_check: assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        i_stb |-> i_cyc)
    else
    begin
        fail_count++;
        $error("stb high without cyc");
    end

    // a ready pulse on either port only comes with an ack
    ready_check: assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        (i_icache_ready || i_dcache_ready) |-> i_ack)
    else
    begin
        fail_count++;
        $error("ready pulse without a matching ack");
    end

    // stb still up after an acked beat means a burst, whose word index steps by one
    wrap_check: assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        (i_stb && i_ack) ##1 i_stb |->
            (adr_view.line.tag == $past(adr_view.line.tag))
            && (adr_view.line.word == 2'($past(adr_view.line.word) + 2'd1)))
    else
    begin
        fail_count++;
        $error("burst address left the line or skipped a word");
    end

    reset_check: assert property (@(posedge i_clk)
        $rose(quick_n_reset) |-> (!i_cyc && !i_stb && !i_we && !i_icache_ready && !i_dcache_ready))
    else
    begin
        fail_count++;
        $error("bus or ready outputs active after reset");
    end

endmodule

bind wb_master_top wb_master_props props_inst
(
    .i_clk          (i_clk),
    .quick_n_reset  (quick_n_reset),
    .i_adr          (o_wb_adr),
    .i_sel          (o_wb_sel),
    .i_we           (o_wb_we),
    .i_dat          (o_wb_dat),
    .i_cyc          (o_wb_cyc),
    .i_stb          (o_wb_stb),
    .i_ack          (i_wb_ack),
    .i_icache_ready (o_icache_ready),
    .i_dcache_ready (o_dcache_ready)
);

`default_nettype wire

// ==== wb_master.f ====
hdl/wb_master_pkg.sv
hdl/wb_req_if.sv
hdl/wb_port_arbiter.sv
hdl/wb_cycle_fsm.sv
hdl/wb_beat_counter.sv
hdl/wb_bus_driver.sv
hdl/wb_master_top.sv
tb/wb_master_props.sv
tb/tb_wb_master.sv
